// File: Makefile
# Verilator build and run of the FP16 adder testbench
TOP := tb_fp16_add

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f tb.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@grep -q "Finished with no errors" sim.log || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: fp16_add_align.sv
/*
 * FP16 adder stage 1
 * Classifies both operands, puts the larger one first and shifts
 * the smaller fraction right with guard and sticky bits
 */
`timescale 1ns/1ps

module fp16_add_align (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  fp16_add_pkg::fp16_t a,
    input  fp16_add_pkg::fp16_t b,
    input  logic [2:0]          frm,
    fp16_stage_if.sender        s12
);
    import fp16_add_pkg::*;

    logic              a_zero;
    logic              b_zero;
    logic              a_inf;
    logic              b_inf;
    logic              a_nan;
    logic              b_nan;
    logic [WORK_W-1:0] a_work;
    logic [WORK_W-1:0] b_work;
    logic              swap;
    logic              big_sign;
    logic [EXP_W-1:0]  big_exp;
    logic [EXP_W-1:0]  small_exp;
    logic [WORK_W-1:0] big_work;
    logic [WORK_W-1:0] small_work;
    logic [EXP_W-1:0]  diff;
    logic [WORK_W-1:0] small_shift;
    logic              lost;
    logic              inv_next;

    // Exponent zero is zero here, subnormals included
    assign a_zero = (a.f.exp == '0);
    assign b_zero = (b.f.exp == '0);
    assign a_inf  = (a.f.exp == EXP_MAX) && (a.f.frac == '0);
    assign b_inf  = (b.f.exp == EXP_MAX) && (b.f.frac == '0);
    assign a_nan  = (a.f.exp == EXP_MAX) && (a.f.frac != '0);
    assign b_nan  = (b.f.exp == EXP_MAX) && (b.f.frac != '0);

    // Hidden bit, fraction, then empty guard and sticky slots
    assign a_work = a_zero ? '0 : {1'b1, a.f.frac, 2'b00};
    assign b_work = b_zero ? '0 : {1'b1, b.f.frac, 2'b00};

    // Order by exponent first, ties broken on the fraction
    assign swap = (b.f.exp > a.f.exp) ||
                  ((b.f.exp == a.f.exp) && (b_work > a_work));

    assign big_sign   = swap ? b.f.sign : a.f.sign;
    assign big_exp    = swap ? b.f.exp  : a.f.exp;
    assign small_exp  = swap ? a.f.exp  : b.f.exp;
    assign big_work   = swap ? b_work   : a_work;
    assign small_work = swap ? a_work   : b_work;

    assign diff        = big_exp - small_exp;
    assign small_shift = small_work >> diff;
    // Any set bit below the shift distance falls off the end
    assign lost = |(small_work & ~({WORK_W{1'b1}} << diff));

    // NaN in, or infinities of opposite sign
    assign inv_next = a_nan || b_nan || (a_inf && b_inf && (a.f.sign != b.f.sign));

    // Not carried on this link
    assign s12.frac_sum = '0;
    assign s12.carry    = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s12.valid <= 1'b0;
        end else begin
            s12.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s12.frm     <= frm;
        s12.sign    <= big_sign;
        s12.exp_max <= big_exp;
        s12.frac_a  <= big_work;
        // Sticky folds into the lowest bit
        s12.frac_b  <= {small_shift[WORK_W-1:1], small_shift[0] | lost};
        s12.eff_sub <= a.f.sign ^ b.f.sign;
        s12.inv     <= inv_next;
        s12.ovf_in  <= (a_inf || b_inf) && !inv_next;
    end

    // Stage strobe stays known once out of reset
    assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(s12.valid))
        else $error("align valid is unknown");

endmodule

// File: fp16_add_input.txt
# name a b frm result flags, all values hex, frm 0 RNE 1 RTZ 2 RDN 3 RUP 4 RMM
# flags bits from 4 down to 0: NV DZ OF UF NX
add_one_one      3C00 3C00 0 4000 00
add_one_two      3C00 4000 0 4200 00
cancel_rne       3C00 BC00 0 0000 00
cancel_rdn       3C00 BC00 2 8000 00
tie_even_rne     3C00 1000 0 3C00 01
tie_even_rmm     3C00 1000 4 3C01 01
tie_even_rtz     3C00 1000 1 3C00 01
tie_even_rup     3C00 1000 3 3C01 01
tie_even_rdn     3C00 1000 2 3C00 01
tie_odd_rne      3C01 1000 0 3C02 01
tie_odd_rtz      3C01 1000 1 3C01 01
neg_tie_rdn      BC00 9000 2 BC01 01
neg_tie_rup      BC00 9000 3 BC00 01
above_half_rne   3C00 1200 0 3C01 01
below_half_rne   3C00 0C00 0 3C00 01
below_half_rup   3C00 0C00 3 3C01 01
carry_tie_rne    3C00 3C01 0 4000 01
carry_tie_rmm    3C00 3C01 4 4001 01
sub_round_rne    4000 9000 0 4000 01
sub_round_rtz    4000 9000 1 3FFF 01
sub_shift_two    3E00 BD00 0 3400 00
sub_shift_ten    3C01 BC00 0 1400 00
underflow_pos    0C01 8C00 0 0000 03
underflow_neg    8C01 0C00 0 8000 03
underflow_edge   2801 A800 0 0000 03
overflow_carry   7BFF 7BFF 0 7C00 05
overflow_neg     FBFF FBFF 0 FC00 05
overflow_round   7BFF 4C00 0 7C00 05
max_finite_rtz   7BFF 4C00 1 7BFF 01
nan_quiet        7E00 3C00 0 7E00 10
nan_signaling    3C00 7C01 0 7E00 10
inf_minus_inf    7C00 FC00 0 7E00 10
inf_plus_inf     7C00 7C00 0 7C00 00
fin_plus_neginf  3C00 FC00 0 FC00 00
subnormal_zero   03FF 3C00 0 3C00 00
neg_zeros        8200 8000 0 8000 00
mode_unused      3C01 1000 5 3C02 01

// File: fp16_add_mantissa.sv
/*
 * FP16 adder stage 2
 * Adds or subtracts the aligned fractions and registers the raw sum,
 * its carry-out and the result sign
 */
`timescale 1ns/1ps

module fp16_add_mantissa (
    input  logic            clk,
    input  logic            rst_n,
    fp16_stage_if.receiver  s12,
    fp16_stage_if.sender    s23
);
    import fp16_add_pkg::*;

    logic [WORK_W:0] wide_sum;
    logic            cancel;
    logic            sign_next;

    always_comb begin
        // One extra bit on top catches the carry-out
        if (s12.eff_sub) begin
            wide_sum = {1'b0, s12.frac_a} - {1'b0, s12.frac_b};
        end else begin
            wide_sum = {1'b0, s12.frac_a} + {1'b0, s12.frac_b};
        end
    end

    // Exact cancellation of opposite-signed operands
    assign cancel = s12.eff_sub && (wide_sum == '0) && !s12.ovf_in;

    // Zero from cancellation is +0, except -0 when rounding down
    assign sign_next = cancel ? (s12.frm == RM_RDN) : s12.sign;

    // Operand fields end here
    assign s23.frac_a  = '0;
    assign s23.frac_b  = '0;
    assign s23.eff_sub = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s23.valid <= 1'b0;
        end else begin
            s23.valid <= s12.valid;
        end
    end

    always_ff @(posedge clk) begin
        s23.frm      <= s12.frm;
        s23.sign     <= sign_next;
        s23.exp_max  <= s12.exp_max;
        s23.frac_sum <= wide_sum[WORK_W-1:0];
        s23.carry    <= wide_sum[WORK_W];
        s23.ovf_in   <= s12.ovf_in;
        s23.inv      <= s12.inv;
    end

    // Aligner puts the larger magnitude first, so a subtract never borrows
    assert property (@(posedge clk) disable iff (!rst_n)
        (s12.valid && s12.eff_sub) |-> (s12.frac_a >= s12.frac_b))
        else $error("subtract with frac_a below frac_b");

endmodule

// File: fp16_add_pkg.sv
/*
 * FP16 adder shared definitions
 * Field widths, rounding-mode codes, flag positions, canonical words
 * and the half-precision word type used by every pipeline stage
 */
package fp16_add_pkg;

    // Half-precision field widths
    localparam int EXP_W  = 5;
    localparam int FRAC_W = 10;
    // Working fraction: hidden bit, ten fraction bits, guard, sticky
    localparam int WORK_W = 13;

    // All-ones exponent marks infinity and NaN
    localparam logic [EXP_W-1:0] EXP_MAX = 5'd31;
    // Largest finite exponent, a carry here overflows
    localparam logic [EXP_W-1:0] EXP_TOP = 5'd30;

    // Rounding-mode codes
    localparam logic [2:0] RM_RNE = 3'b000;
    localparam logic [2:0] RM_RTZ = 3'b001;
    localparam logic [2:0] RM_RDN = 3'b010;
    localparam logic [2:0] RM_RUP = 3'b011;
    localparam logic [2:0] RM_RMM = 3'b100;

    // Bit positions in the exception flag word
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    // Canonical quiet NaN
    localparam logic [15:0] QNAN_WORD = 16'h7E00;
    // Infinity magnitude, sign bit left out
    localparam logic [14:0] INF_MAG   = 15'h7C00;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp16_fields_t;

    // One FP16 word, seen as raw bits or as its fields
    typedef union packed {
        logic [15:0]  raw;
        fp16_fields_t f;
    } fp16_t;

endpackage

// File: fp16_add_round.sv
/*
 * FP16 adder stage 3
 * Normalizes the raw sum, rounds it per the rounding mode, detects
 * overflow and underflow and builds the result word and flags
 */
`timescale 1ns/1ps

module fp16_add_round (
    input  logic                clk,
    input  logic                rst_n,
    fp16_stage_if.receiver      s23,
    output logic                out_valid,
    output fp16_add_pkg::fp16_t result,
    output logic [4:0]          flags
);
    import fp16_add_pkg::*;

    logic [3:0]        lzc;
    logic [WORK_W-1:0] norm_frac;
    logic [11:0]       round_this;
    logic [EXP_W:0]    exp_norm;
    logic [EXP_W:0]    exp_final;
    logic              sum_zero;
    logic              unf;
    logic              ovf;
    logic [2:0]        mode;
    logic              lsb;
    logic              guard;
    logic              sticky;
    logic              rnd_up;
    logic [FRAC_W:0]   mant_rnd;
    fp16_t             res_next;
    logic [4:0]        flag_next;

    // Count of zeros above the leading one, 13 for an all-zero sum
    function automatic logic [3:0] lead_zeros(input logic [WORK_W-1:0] v);
        logic [3:0] n;
        logic       found;
        n = 4'd0;
        found = 1'b0;
        for (int i = WORK_W - 1; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 4'd1;
                end
            end
        end
        return n;
    endfunction

    assign lzc       = lead_zeros(s23.frac_sum);
    assign norm_frac = s23.frac_sum << lzc;
    assign sum_zero  = (s23.frac_sum == '0) && !s23.carry;

    // Normalize
    always_comb begin
        unf = 1'b0;
        if (s23.carry) begin
            // Carry is the new hidden bit, drop one place and keep sticky
            round_this = {s23.frac_sum[WORK_W-1:2], s23.frac_sum[1] | s23.frac_sum[0]};
            exp_norm   = {1'b0, s23.exp_max} + 6'd1;
        end else begin
            round_this = norm_frac[11:0];
            exp_norm   = {1'b0, s23.exp_max} - {2'b00, lzc};
            // A zero exponent would be subnormal, so it flushes too
            unf = !sum_zero && ({2'b00, lzc} >= {1'b0, s23.exp_max});
        end
    end

    // Unused mode codes fall back to nearest even
    assign mode   = (s23.frm > RM_RMM) ? RM_RNE : s23.frm;
    assign lsb    = round_this[2];
    assign guard  = round_this[1];
    assign sticky = round_this[0];

    always_comb begin
        case (mode)
            RM_RNE:  rnd_up = guard & (sticky | lsb);
            RM_RTZ:  rnd_up = 1'b0;
            RM_RDN:  rnd_up = s23.sign & (guard | sticky);
            RM_RUP:  rnd_up = ~s23.sign & (guard | sticky);
            RM_RMM:  rnd_up = guard;
            default: rnd_up = guard & (sticky | lsb);
        endcase
    end

    // Mantissa carry bumps the exponent, fraction wraps to zero
    assign mant_rnd  = {1'b0, round_this[11:2]} + {{FRAC_W{1'b0}}, rnd_up};
    assign exp_final = exp_norm + {{EXP_W{1'b0}}, mant_rnd[FRAC_W]};
    // Covers a carry at EXP_TOP and a rounding carry into EXP_MAX
    assign ovf = !sum_zero && !unf && (exp_final >= {1'b0, EXP_MAX});

    // Result select, first match wins
    always_comb begin
        res_next.raw = '0;
        flag_next    = '0;
        if (s23.inv) begin
            res_next.raw       = QNAN_WORD;
            flag_next[FLAG_NV] = 1'b1;
        end else if (s23.ovf_in) begin
            // Infinite operand passes through exactly
            res_next.f.sign = s23.sign;
            {res_next.f.exp, res_next.f.frac} = INF_MAG;
        end else if (ovf) begin
            res_next.f.sign = s23.sign;
            {res_next.f.exp, res_next.f.frac} = INF_MAG;
            flag_next[FLAG_OF] = 1'b1;
            flag_next[FLAG_NX] = 1'b1;
        end else if (unf) begin
            res_next.f.sign    = s23.sign;
            flag_next[FLAG_UF] = 1'b1;
            flag_next[FLAG_NX] = 1'b1;
        end else if (sum_zero) begin
            res_next.f.sign = s23.sign;
        end else begin
            res_next.f.sign    = s23.sign;
            res_next.f.exp     = exp_final[EXP_W-1:0];
            res_next.f.frac    = mant_rnd[FRAC_W-1:0];
            flag_next[FLAG_NX] = guard | sticky;
        end
        // No division, so DZ never rises
        flag_next[FLAG_DZ] = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s23.valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= res_next;
        flags  <= flag_next;
    end

    // A live stage 2 item leaves one cycle later with a fully known word
    assert property (@(posedge clk) disable iff (!rst_n)
        s23.valid |=> (out_valid && !$isunknown({result, flags})))
        else $error("stage 3 item missing or unknown at the output");

endmodule

// File: fp16_add_top.sv
/*
 * FP16 adder top level
 * Three-stage pipelined half-precision adder, one result per cycle,
 * align then mantissa add then normalize and round
 */
`timescale 1ns/1ps

module fp16_add_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [15:0] a,
    input  logic [15:0] b,
    input  logic [2:0]  frm,
    output logic        out_valid,
    output logic [15:0] result,
    output logic [4:0]  flags
);

    // Align to mantissa link
    fp16_stage_if s12 ();
    // Mantissa to round link
    fp16_stage_if s23 ();

    fp16_add_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .frm      (frm),
        .s12      (s12.sender)
    );

    fp16_add_mantissa u_mantissa (
        .clk   (clk),
        .rst_n (rst_n),
        .s12   (s12.receiver),
        .s23   (s23.sender)
    );

    fp16_add_round u_round (
        .clk       (clk),
        .rst_n     (rst_n),
        .s23       (s23.receiver),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

endmodule

// File: fp16_stage_if.sv
/*
 * FP16 adder stage link
 * Carries one in-flight addition from one pipeline stage to the next
 */
`timescale 1ns/1ps

interface fp16_stage_if;
    import fp16_add_pkg::*;

    logic              valid;
    logic [2:0]        frm;
    logic              sign;
    logic [EXP_W-1:0]  exp_max;
    // Aligned operands, live on the align to mantissa link
    logic [WORK_W-1:0] frac_a;
    logic [WORK_W-1:0] frac_b;
    logic              eff_sub;
    // Raw sum and carry-out, live on the mantissa to round link
    logic [WORK_W-1:0] frac_sum;
    logic              carry;
    // Infinite operand and invalid operation
    logic              ovf_in;
    logic              inv;

    modport sender (
        output valid, frm, sign, exp_max, frac_a, frac_b, eff_sub,
               frac_sum, carry, ovf_in, inv
    );

    modport receiver (
        input valid, frm, sign, exp_max, frac_a, frac_b, eff_sub,
              frac_sum, carry, ovf_in, inv
    );

endinterface

// File: tb.f
fp16_add_pkg.sv
fp16_stage_if.sv
fp16_add_align.sv
fp16_add_mantissa.sv
fp16_add_round.sv
fp16_add_top.sv
tb_fp16_add.sv

// File: tb_fp16_add.sv
/*
 * FP16 adder testbench
 * Reads addition vectors from the data file, feeds them back-to-back and
 * then with idle gaps, and checks result, flags and latency in order
 */
`timescale 1ns/1ps

module tb_fp16_add;

    localparam int MAX_VEC     = 64;
    localparam int LATENCY     = 3;
    localparam int DRAIN_LIMIT = 40;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic [15:0] a;
    logic [15:0] b;
    logic [2:0]  frm;
    logic        out_valid;
    logic [15:0] result;
    logic [4:0]  flags;

    // Vector table as read from the data file
    string       vec_name [MAX_VEC];
    logic [15:0] vec_a    [MAX_VEC];
    logic [15:0] vec_b    [MAX_VEC];
    logic [2:0]  vec_frm  [MAX_VEC];
    logic [15:0] vec_res  [MAX_VEC];
    logic [4:0]  vec_flags[MAX_VEC];
    int          num_vec;

    // In flight: vector index, edge count when driven, pass number
    int pend_idx[$];
    int pend_issue[$];
    int pend_pass[$];

    int cycle;
    int pass_count;
    int fail_count;
    int error_count;

    fp16_add_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .frm       (frm),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Rising edges since time zero
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic compare_value(input string label, input logic [31:0] expected,
                                 input logic [31:0] actual, output bit ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("FAIL %s expected %0h actual %0h", label, expected, actual);
        end
    endtask

    task automatic check_output();
        int    idx;
        int    issue;
        int    pass_no;
        string label;
        bit    ok_res;
        bit    ok_flags;
        bit    ok_lat;
        idx     = pend_idx.pop_front();
        issue   = pend_issue.pop_front();
        pass_no = pend_pass.pop_front();
        label   = $sformatf("%s.%0d", vec_name[idx], pass_no);
        compare_value({label, " result"}, {16'h0, vec_res[idx]}, {16'h0, result}, ok_res);
        compare_value({label, " flags"}, {27'h0, vec_flags[idx]}, {27'h0, flags}, ok_flags);
        // Output must show up exactly three cycles after the vector was driven
        compare_value({label, " latency"}, LATENCY, cycle - issue, ok_lat);
        if (ok_res && ok_flags && ok_lat) begin
            pass_count++;
            $display("ok   %s result %h flags %b", label, result, flags);
        end else begin
            fail_count++;
        end
    endtask

    // Outputs sampled on the falling edge, half a period after they settle
    always @(negedge clk) begin
        if (!rst_n) begin
            if (out_valid !== 1'b0) begin
                $display("out_valid is not low while reset is held");
                error_count++;
            end
        end else if (out_valid === 1'b1) begin
            if (pend_idx.size() == 0) begin
                $display("out_valid is high with no addition in flight");
                error_count++;
            end else begin
                check_output();
            end
        end else if (out_valid !== 1'b0) begin
            $display("out_valid is unknown after reset");
            error_count++;
        end
    end

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [15:0] va;
        logic [15:0] vb;
        logic [2:0]  vm;
        logic [15:0] vr;
        logic [4:0]  vfl;
        num_vec = 0;
        fd = $fopen("fp16_add_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file fp16_add_input.txt");
            error_count++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            code = $fgets(line, fd);
            // Skip comment and blank lines
            if (code > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                code = $sscanf(line, "%s %h %h %h %h %h", name, va, vb, vm, vr, vfl);
                if (code == 6) begin
                    vec_name[num_vec]  = name;
                    vec_a[num_vec]     = va;
                    vec_b[num_vec]     = vb;
                    vec_frm[num_vec]   = vm;
                    vec_res[num_vec]   = vr;
                    vec_flags[num_vec] = vfl;
                    num_vec++;
                end else begin
                    $display("malformed line in the vector file: %s", line);
                    error_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // New inputs change on the falling edge, captured on the next rising one
    task automatic drive_vector(input int idx, input int pass_no);
        @(negedge clk);
        in_valid <= 1'b1;
        a        <= vec_a[idx];
        b        <= vec_b[idx];
        frm      <= vec_frm[idx];
        pend_idx.push_back(idx);
        pend_issue.push_back(cycle);
        pend_pass.push_back(pass_no);
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            in_valid <= 1'b0;
        end
    endtask

    initial begin
        int wait_cycles;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        a           = '0;
        b           = '0;
        frm         = '0;
        cycle       = 0;
        pass_count  = 0;
        fail_count  = 0;
        error_count = 0;
        load_vectors();

        // Four rising edges with reset held
        repeat (4) @(negedge clk);
        rst_n <= 1'b1;

        // First pass, one vector per cycle
        for (int i = 0; i < num_vec; i++) begin
            drive_vector(i, 1);
        end
        drive_idle(3);

        // Second pass with gaps of one to three idle cycles
        for (int i = 0; i < num_vec; i++) begin
            drive_vector(i, 2);
            drive_idle(1 + i % 3);
        end

        wait_cycles = 0;
        while (pend_idx.size() > 0 && wait_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (pend_idx.size() > 0) begin
            $display("timed out waiting, %0d results never came out", pend_idx.size());
            error_count++;
        end
        // Quiet tail, any stray out_valid shows up here
        drive_idle(5);

        $display("%0d vectors, %0d passed, %0d failed, %0d other errors",
                 num_vec, pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0 && num_vec > 0 &&
            pass_count == 2 * num_vec) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
